//--- hw/chipbus_cfg.svh
// build constants for the chip-bus block: widths, address map, reset length
// include wherever a width or page value is needed

`ifndef CHIPBUS_CFG_SVH
`define CHIPBUS_CFG_SVH

// ---------------------------------------------------------------------------
// bus widths
// ---------------------------------------------------------------------------
`define CB_ADDR_W     23      // word address, bits 23:1
`define CB_DATA_W     16      // data bus
`define CB_UNITS      2       // timer units, one per byte lane

// ---------------------------------------------------------------------------
// address map, value of addr[23:16]
// ---------------------------------------------------------------------------
`define CB_CIA_PAGE   8'hBF   // cia space
`define CB_RTC_PAGE   8'hDC   // real-time clock nibbles

// ---------------------------------------------------------------------------
// system reset stretch
// ---------------------------------------------------------------------------
`define CB_RST_FRAMES 4       // frame events held after a request ends

`endif

//--- hw/chipbus_pkg.sv
// shared types of the chip-bus block
// referenced by scoped name from every module and the testbench

`include "chipbus_cfg.svh"

package chipbus_pkg;

	// bus payload types
	typedef logic [`CB_ADDR_W:1]  bus_addr_t;   // indexed like the cpu pins, 23:1
	typedef logic [`CB_DATA_W-1:0] bus_data_t;
	typedef logic [7:0]           lane_t;       // one byte lane

	// timer register select, from addr[11:8]
	typedef enum logic [3:0] {
		TA_LO = 4'd0,   // counter / latch low byte
		TA_HI = 4'd1,   // counter / latch high byte
		ICR   = 4'd2,   // interrupt control
		CRA   = 4'd3    // control, bit 0 start, bit 3 one-shot
	} cia_reg_e;

	// interrupt level seen by the processor
	typedef enum logic [2:0] {
		IPL_NONE  = 3'd0,
		IPL_PORTS = 3'd2,   // unit 0
		IPL_EXTER = 3'd6    // unit 1
	} ipl_e;

	// reset sequencer
	typedef enum logic [1:0] {
		RST_HOLD,     // request still active
		RST_COUNT,    // counting frame events
		RST_RUN       // system released
	} rst_state_e;

endpackage

//--- hw/bus_decoder.sv
// address decoder that turns each rising edge of the address strobe into
// one-cycle access strobes for the timer units and the rtc

`timescale 1ns/1ns
`include "chipbus_cfg.svh"

module bus_decoder (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  as,        // active-high address strobe
	input  logic                  rw,        // 1 = read
	input  chipbus_pkg::bus_addr_t addr,
	output logic                  acc_rd,
	output logic                  acc_wr,
	output logic                  acc_any,   // any cycle mapped or not
	output chipbus_pkg::cia_reg_e acc_reg,
	output logic [`CB_UNITS-1:0]  cia_sel,
	output logic                  rtc_sel,
	output logic [3:0]            rtc_idx
);

	logic                 as_q;       // strobe from last edge
	logic                 as_rise;
	logic                 cia_page;
	logic                 rtc_page;
	logic [`CB_UNITS-1:0] unit_hit;

	assign as_rise  = as & ~as_q;
	assign cia_page = (addr[23:16] == `CB_CIA_PAGE);
	assign rtc_page = (addr[23:16] == `CB_RTC_PAGE);

	// unit i answers when addr[12+i] is low and both may hit
	always_comb begin
		for (int i = 0; i < `CB_UNITS; i++) begin
			unit_hit[i] = cia_page & ~addr[12 + i];
		end
	end

	// one pulse per bus cycle on every strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			as_q    <= 1'b0;
			acc_rd  <= 1'b0;
			acc_wr  <= 1'b0;
			acc_any <= 1'b0;
			cia_sel <= '0;
			rtc_sel <= 1'b0;
		end else begin
			as_q    <= as;
			acc_rd  <= as_rise & rw;
			acc_wr  <= as_rise & ~rw;
			acc_any <= as_rise;
			cia_sel <= as_rise ? unit_hit : '0;
			rtc_sel <= as_rise & rtc_page;   // writes dropped later
		end
	end

	// register field and nibble index are only meaningful with a strobe
	always_ff @(posedge clk) begin
		if (as_rise) begin
			acc_reg <= chipbus_pkg::cia_reg_e'(addr[11:8]);
			rtc_idx <= addr[5:2];
		end
	end

	// a held strobe never gives a second access
	assert property (@(posedge clk) disable iff (reset)
		acc_any |=> !acc_any);

endmodule

//--- hw/cia_timer.sv
// one cia-style interval timer on a single byte lane
// 16-bit latch and down counter, start/one-shot control, one interrupt source
// accesses come as one-cycle strobes from the decoder

`timescale 1ns/1ns
`include "chipbus_cfg.svh"

module cia_timer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sel,      // this unit addressed
	input  logic                  acc_rd,
	input  logic                  acc_wr,
	input  chipbus_pkg::cia_reg_e acc_reg,
	input  chipbus_pkg::lane_t    wdata,
	input  logic                  tick,     // counts on the rising edge
	output chipbus_pkg::lane_t    rdata,    // zero unless reading
	output logic                  ack,
	output logic                  irq
);

	logic               tick_q;
	logic               tick_rise;
	logic [15:0]        ta_latch;
	logic [15:0]        ta_cnt;
	chipbus_pkg::lane_t cra;        // control reg a
	logic               icr_mask;
	logic               icr_flag;   // underflow seen
	logic               underflow;
	logic               rd_hit;
	logic               wr_hit;

	assign tick_rise = tick & ~tick_q;
	// a tick while the counter sits at zero is the underflow
	assign underflow = tick_rise & cra[0] & (ta_cnt == 16'd0);
	assign rd_hit    = sel & acc_rd;
	assign wr_hit    = sel & acc_wr;
	assign irq       = icr_flag & icr_mask;

	always_ff @(posedge clk) begin
		if (reset) begin
			tick_q   <= 1'b0;
			ta_latch <= 16'd0;
			ta_cnt   <= 16'd0;
			cra      <= '0;
			icr_mask <= 1'b0;
			icr_flag <= 1'b0;
			ack      <= 1'b0;
			rdata    <= '0;
		end else begin
			tick_q <= tick;
			ack    <= sel & (acc_rd | acc_wr);   // one cycle behind the strobe

			// ------------------------------------------------------------------
			// counting
			// ------------------------------------------------------------------
			if (underflow) begin
				ta_cnt <= ta_latch;   // reload
				if (cra[3])
					cra[0] <= 1'b0;   // one-shot stops itself
			end else if (tick_rise && cra[0]) begin
				ta_cnt <= ta_cnt - 16'd1;
			end

			// read clears the flag but an underflow in the same cycle wins
			if (rd_hit && acc_reg == chipbus_pkg::ICR)
				icr_flag <= 1'b0;
			if (underflow)
				icr_flag <= 1'b1;

			// ------------------------------------------------------------------
			// register writes override the counter path
			// ------------------------------------------------------------------
			if (wr_hit) begin
				case (acc_reg)
					chipbus_pkg::TA_LO: ta_latch[7:0] <= wdata;
					chipbus_pkg::TA_HI: begin
						ta_latch[15:8] <= wdata;
						if (!cra[0])
							ta_cnt <= {wdata, ta_latch[7:0]};   // load when stopped
					end
					chipbus_pkg::ICR: begin
						// bit 7 picks set or clear for the mask bit
						if (wdata[7])
							icr_mask <= icr_mask | wdata[0];
						else
							icr_mask <= icr_mask & ~wdata[0];
					end
					chipbus_pkg::CRA: cra <= wdata;
					default: ;   // unused selects ignore writes
				endcase
			end

			// ------------------------------------------------------------------
			// register reads
			// ------------------------------------------------------------------
			rdata <= '0;
			if (rd_hit) begin
				case (acc_reg)
					chipbus_pkg::TA_LO: rdata <= ta_cnt[7:0];
					chipbus_pkg::TA_HI: rdata <= ta_cnt[15:8];
					chipbus_pkg::ICR:   rdata <= {irq, 6'b000000, icr_flag};
					chipbus_pkg::CRA:   rdata <= cra;
					default:            rdata <= '0;
				endcase
			end
		end
	end

	// a select always comes with exactly one read or write strobe
	assert property (@(posedge clk) disable iff (reset)
		sel |-> (acc_rd ^ acc_wr));

endmodule

//--- hw/bus_return.sv
// read-data return path that merges unit lanes and the rtc nibble
// dtack rises two cycles after the strobe for every target and holds until as falls
// also encodes the unit interrupts into a processor level

`timescale 1ns/1ns
`include "chipbus_cfg.svh"

module bus_return (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   as,
	input  logic                   acc_any,
	input  logic                   acc_rd,
	input  logic                   rtc_sel,
	input  logic [3:0]             rtc_idx,
	input  logic [63:0]            rtc,
	input  logic [`CB_UNITS-1:0]   unit_ack,
	input  chipbus_pkg::lane_t     unit_rdata [`CB_UNITS],
	input  logic [`CB_UNITS-1:0]   unit_irq,
	output chipbus_pkg::bus_data_t rdata,
	output logic                   dtack,
	output chipbus_pkg::ipl_e      ipl
);

	logic                   any_q;     // strobe delayed to unit timing
	logic [3:0]             rtc_nib;
	logic                   done;
	chipbus_pkg::bus_data_t merged;

	// unit ack and delayed strobe land on the same cycle
	assign done = any_q | (|unit_ack);

	// lane i of the bus belongs to unit i
	always_comb begin
		merged      = '0;
		merged[3:0] = rtc_nib;
		for (int i = 0; i < `CB_UNITS; i++) begin
			merged[8*i +: 8] = merged[8*i +: 8] | unit_rdata[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			any_q <= 1'b0;
			dtack <= 1'b0;
			ipl   <= chipbus_pkg::IPL_NONE;
		end else begin
			any_q <= acc_any;
			if (!as)
				dtack <= 1'b0;   // drop one cycle after as
			else if (done)
				dtack <= 1'b1;
			// unit 1 has the higher level
			if (unit_irq[1])
				ipl <= chipbus_pkg::IPL_EXTER;
			else if (unit_irq[0])
				ipl <= chipbus_pkg::IPL_PORTS;
			else
				ipl <= chipbus_pkg::IPL_NONE;
		end
	end

	// rtc nibble read is staged to meet the unit schedule
	always_ff @(posedge clk) begin
		rtc_nib <= (rtc_sel && acc_rd) ? rtc[{rtc_idx, 2'b00} +: 4] : 4'h0;
		if (!as)
			rdata <= '0;
		else if (done)
			rdata <= merged;   // held with dtack
	end

	// dtack only rises for a strobe taken two cycles before
	assert property (@(posedge clk) disable iff (reset)
		$rose(dtack) |-> $past(acc_any, 2));

endmodule

//--- hw/reset_sequencer.sv
// system reset stretcher: holds sys_reset during any reset request and for
// a fixed count of frame events after it ends

`timescale 1ns/1ns
`include "chipbus_cfg.svh"

module reset_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic rst_req,   // soft reset request
	input  logic frame,     // one pulse per frame
	output logic sys_reset
);

	localparam int CNT_W = $clog2(`CB_RST_FRAMES + 1);

	chipbus_pkg::rst_state_e state;
	logic [CNT_W-1:0]        frame_cnt;

	always_ff @(posedge clk) begin
		if (reset || rst_req) begin
			state     <= chipbus_pkg::RST_HOLD;
			frame_cnt <= '0;
		end else begin
			case (state)
				chipbus_pkg::RST_HOLD: begin
					state     <= chipbus_pkg::RST_COUNT;   // request gone, start counting
					frame_cnt <= '0;
				end
				chipbus_pkg::RST_COUNT: begin
					if (frame) begin
						frame_cnt <= frame_cnt + 1'b1;
						if (frame_cnt == CNT_W'(`CB_RST_FRAMES - 1))
							state <= chipbus_pkg::RST_RUN;   // last frame seen
					end
				end
				chipbus_pkg::RST_RUN: ;   // stay until next request
				default: state <= chipbus_pkg::RST_HOLD;
			endcase
		end
	end

	assign sys_reset = (state != chipbus_pkg::RST_RUN);

endmodule

//--- hw/chipbus_top.sv
// top level of the chip-bus block: decoder, two timer units on the byte
// lanes, read-data return and the system reset sequencer

`timescale 1ns/1ns
`include "chipbus_cfg.svh"

module chipbus_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rst_req,
	input  logic                   frame,
	input  logic                   as,
	input  logic                   rw,
	input  chipbus_pkg::bus_addr_t addr,
	input  chipbus_pkg::bus_data_t wdata,
	input  logic [`CB_UNITS-1:0]   tick,
	input  logic [63:0]            rtc,
	output chipbus_pkg::bus_data_t rdata,
	output logic                   dtack,
	output chipbus_pkg::ipl_e      ipl,
	output logic                   rst_out
);

	// ---------------------------------------------------------------------------
	// internal strobes and unit returns
	// ---------------------------------------------------------------------------
	logic                  sys_reset;
	logic                  acc_rd;
	logic                  acc_wr;
	logic                  acc_any;
	chipbus_pkg::cia_reg_e acc_reg;
	logic [`CB_UNITS-1:0]  cia_sel;
	logic                  rtc_sel;
	logic [3:0]            rtc_idx;
	logic [`CB_UNITS-1:0]  unit_ack;
	logic [`CB_UNITS-1:0]  unit_irq;
	chipbus_pkg::lane_t    unit_rdata [`CB_UNITS];

	assign rst_out = sys_reset;   // reset status out

	reset_sequencer u_rst (
		.clk       (clk),
		.reset     (reset),
		.rst_req   (rst_req),
		.frame     (frame),
		.sys_reset (sys_reset)
	);

	bus_decoder u_dec (
		.clk     (clk),
		.reset   (sys_reset),
		.as      (as),
		.rw      (rw),
		.addr    (addr),
		.acc_rd  (acc_rd),
		.acc_wr  (acc_wr),
		.acc_any (acc_any),
		.acc_reg (acc_reg),
		.cia_sel (cia_sel),
		.rtc_sel (rtc_sel),
		.rtc_idx (rtc_idx)
	);

	// unit i sits on lane i
	for (genvar g = 0; g < `CB_UNITS; g++) begin : g_unit
		cia_timer u_timer (
			.clk     (clk),
			.reset   (sys_reset),
			.sel     (cia_sel[g]),
			.acc_rd  (acc_rd),
			.acc_wr  (acc_wr),
			.acc_reg (acc_reg),
			.wdata   (wdata[8*g +: 8]),
			.tick    (tick[g]),
			.rdata   (unit_rdata[g]),
			.ack     (unit_ack[g]),
			.irq     (unit_irq[g])
		);
	end

	bus_return u_ret (
		.clk        (clk),
		.reset      (sys_reset),
		.as         (as),
		.acc_any    (acc_any),
		.acc_rd     (acc_rd),
		.rtc_sel    (rtc_sel),
		.rtc_idx    (rtc_idx),
		.rtc        (rtc),
		.unit_ack   (unit_ack),
		.unit_rdata (unit_rdata),
		.unit_irq   (unit_irq),
		.rdata      (rdata),
		.dtack      (dtack),
		.ipl        (ipl)
	);

endmodule

//--- tests/tb_chipbus.sv
// testbench for the chip-bus block
// runs the operations of tests/chipbus_stim.txt against chipbus_top
// bus cycles use the as/dtack handshake, timer ticks, frame pulses and reset requests
// each result is compared as it arrives

`timescale 1ns/1ns
`include "chipbus_cfg.svh"

module tb_chipbus;

	localparam int          CLK_PERIOD  = 100;
	localparam int          DRIVE_SKEW  = 10;    // inputs change this long after posedge
	localparam int          DTACK_LIMIT = 16;    // cycles to wait for a handshake edge
	localparam logic [63:0] RTC_WORD    = 64'h5A3C_96E1_0F7B_D248;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   rst_req;
	logic                   frame;
	logic                   as;
	logic                   rw;
	chipbus_pkg::bus_addr_t addr;
	chipbus_pkg::bus_data_t wdata;
	logic [`CB_UNITS-1:0]   tick;
	logic [63:0]            rtc;
	chipbus_pkg::bus_data_t rdata;
	logic                   dtack;
	chipbus_pkg::ipl_e      ipl;
	logic                   rst_out;

	int fd;
	int n_lines;
	int wd_cycles   = 0;   // watchdog budget in cycles once the file is counted
	int frames_left = 0;   // frames still owed before rst_out may drop

	always #(CLK_PERIOD / 2) clk = ~clk;

	chipbus_top dut0 (
		.clk     (clk),
		.reset   (reset),
		.rst_req (rst_req),
		.frame   (frame),
		.as      (as),
		.rw      (rw),
		.addr    (addr),
		.wdata   (wdata),
		.tick    (tick),
		.rtc     (rtc),
		.rdata   (rdata),
		.dtack   (dtack),
		.ipl     (ipl),
		.rst_out (rst_out)
	);

	// ------------------------------------------------------------------------
	// failure exit and compare tasks
	// ------------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_data(input string name, input chipbus_pkg::bus_data_t got,
			input chipbus_pkg::bus_data_t exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_ipl(input string name, input chipbus_pkg::ipl_e got,
			input chipbus_pkg::ipl_e exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t ns: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_reset(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("Mismatch at %0t ns: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	// ------------------------------------------------------------------------
	// stimulus tasks start and end at posedge plus skew
	// ------------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_SKEW;
	endtask

	// dtack must come two edges after the edge that sees as
	task automatic bus_cycle(input logic is_read, input logic [23:0] byte_addr,
			input chipbus_pkg::bus_data_t wd, output chipbus_pkg::bus_data_t rd);
		int cycles;
		as     = 1'b1;
		rw     = is_read;
		addr   = byte_addr[23:1];   // word address as on the cpu pins
		wdata  = wd;
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
		end while (!dtack && cycles < DTACK_LIMIT);
		if (!dtack)
			abort_run($sformatf("No dtack within %0d cycles for address %h at %0t ns",
				DTACK_LIMIT, byte_addr, $time));
		check_cycles("dtack latency", cycles - 1, 2);
		rd     = rdata;
		as     = 1'b0;
		rw     = 1'b1;
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
		end while (dtack && cycles < DTACK_LIMIT);
		if (dtack)
			abort_run($sformatf("dtack stayed high after as fell, at %0t ns", $time));
	endtask

	// rst_out tracked against the frames still owed
	task automatic pulse_frames(input int n);
		for (int k = 0; k < n; k++) begin
			check_reset("rst_out", rst_out, frames_left > 0);
			frame = 1'b1;
			next_cycle();
			frame = 1'b0;
			if (frames_left > 0)
				frames_left--;
			check_reset("rst_out", rst_out, frames_left > 0);   // drops on the last frame
			next_cycle();
		end
	endtask

	task automatic pulse_ticks(input int unit, input int n);
		for (int k = 0; k < n; k++) begin
			tick[unit] = 1'b1;
			next_cycle();
			tick[unit] = 1'b0;
			next_cycle();
		end
	endtask

	// soft reset request held two cycles
	task automatic request_reset();
		rst_req = 1'b1;
		next_cycle();
		check_reset("rst_out", rst_out, 1'b1);
		next_cycle();
		rst_req     = 1'b0;
		frames_left = `CB_RST_FRAMES;
		next_cycle();   // sequencer starts counting here
		check_reset("rst_out", rst_out, 1'b1);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin : run_stim
		logic [8*8-1:0]         op_tok;
		logic [8*128-1:0]       skip_line;
		logic [31:0]            arg_a;
		logic [31:0]            arg_b;
		int                     n_got;
		chipbus_pkg::bus_data_t rd;
		reset   = 1'b1;
		rst_req = 1'b0;
		frame   = 1'b0;
		as      = 1'b0;
		rw      = 1'b1;
		addr    = '0;
		wdata   = '0;
		tick    = '0;
		rtc     = RTC_WORD;   // fixed for the whole run

		// count lines first so the watchdog scales with them
		fd = $fopen("tests/chipbus_stim.txt", "r");
		if (fd == 0)
			abort_run("Cannot open the stimulus file tests/chipbus_stim.txt");
		n_lines = 0;
		while (!$feof(fd)) begin
			if ($fgets(skip_line, fd) > 0)
				n_lines++;
		end
		$fclose(fd);
		wd_cycles = (n_lines + 4) * 40;
		fd = $fopen("tests/chipbus_stim.txt", "r");

		repeat (2) @(posedge clk);
		#DRIVE_SKEW;
		reset       = 1'b0;
		frames_left = `CB_RST_FRAMES;
		next_cycle();

		while (!$feof(fd)) begin
			n_got = $fscanf(fd, "%s", op_tok);
			if (n_got == 1) begin
				case (op_tok)
					"#": n_got = $fgets(skip_line, fd);   // column notes
					"F": begin
						n_got = $fscanf(fd, "%h", arg_a);
						pulse_frames(arg_a);
					end
					"W": begin
						n_got = $fscanf(fd, "%h %h", arg_a, arg_b);
						bus_cycle(1'b0, arg_a[23:0], arg_b[15:0], rd);
					end
					"R": begin
						n_got = $fscanf(fd, "%h %h", arg_a, arg_b);
						bus_cycle(1'b1, arg_a[23:0], 16'h0000, rd);
						check_data("rdata", rd, arg_b[15:0]);
					end
					"T": begin
						n_got = $fscanf(fd, "%h %h", arg_a, arg_b);
						pulse_ticks(arg_a, arg_b);
					end
					"I": begin
						n_got = $fscanf(fd, "%h", arg_a);
						check_ipl("ipl", ipl, chipbus_pkg::ipl_e'(arg_a[2:0]));
					end
					"Q": request_reset();
					default: abort_run($sformatf("Unknown operation %s in the stimulus file",
						op_tok));
				endcase
			end
		end
		$fclose(fd);

		$display("All tests passed");
		$finish;
	end

	// watchdog starts once the budget is known
	initial begin : watchdog
		wait (wd_cycles > 0);
		#(wd_cycles * CLK_PERIOD);
		abort_run($sformatf("Watchdog expired after %0d cycles, the run did not finish",
			wd_cycles));
	end

endmodule

//--- tests/chipbus_stim.txt
# ops, hex args: F frames | W addr data | R addr expected | T unit ticks | I ipl | Q
# addr is the 24-bit byte address, data and expected are the 16-bit bus word
F 4
R 100000 0000
R BFE501 0000
W BFE001 0006
W BFE101 0000
W BFE301 0009
T 0 2
R BFE001 0004
W BFE201 0081
T 0 5
I 2
R BFE001 0006
R BFE201 0081
I 0
W BFD001 0300
W BFD101 0000
W BFD201 8100
W BFD301 0900
T 1 4
I 6
W BFE301 0009
T 0 7
I 6
R BFC201 8181
I 0
R DC0000 0008
R DC0014 0007
W DC0024 FFFF
R DC0024 000E
R BFC001 0306
Q
F 4
R BFC001 0000

//--- files.f
+incdir+hw
hw/chipbus_pkg.sv
hw/bus_decoder.sv
hw/cia_timer.sv
hw/bus_return.sv
hw/reset_sequencer.sv
hw/chipbus_top.sv
tests/tb_chipbus.sv

//--- Bender.yml
package:
  name: chipbus

sources:
  - include_dirs:
      - hw
    files:
      - hw/chipbus_pkg.sv
      - hw/bus_decoder.sv
      - hw/cia_timer.sv
      - hw/bus_return.sv
      - hw/reset_sequencer.sv
      - hw/chipbus_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_chipbus.sv
